//--- src/isaPkg.sv
package isaPkg;

  localparam int classWidth = 7;

  // bit positions in a class vector
  localparam int clsJump = 0;
  localparam int clsAlu = 1;
  localparam int clsShift = 2;
  localparam int clsMul = 3;
  localparam int clsLoad = 4;
  localparam int clsStore = 5;
  localparam int clsSys = 6;

  typedef logic [classWidth-1:0] instrClass;

  // same 32 bits, read as long form or as compact form
  typedef union packed {
    struct packed {
      logic [23:0] operand;
      logic [7:0] mainOp;
    } longForm;
    struct packed {
      logic [25:0] operand;
      logic [5:0] subOp;
    } compactForm;
  } instrWord;

  // long form main opcode ranges
  localparam logic [7:0] aluMulLast = 8'd39;
  localparam logic [7:0] shiftFirst = 8'd40;
  localparam logic [7:0] shiftLast = 8'd45;
  localparam logic [7:0] aluFirst = 8'd46;
  localparam logic [7:0] aluLast = 8'd53;
  localparam logic [7:0] memFirst = 8'd64;
  localparam logic [7:0] memLast = 8'd127;
  localparam logic [7:0] condJumpFirst = 8'd160;
  localparam logic [7:0] condJumpLast = 8'd175;
  localparam logic [7:0] longJumpFirst = 8'd180;
  localparam logic [7:0] longJumpLast = 8'd181;
  localparam logic [7:0] sysOpcode = 8'd255;

  // compact form sub opcode ranges
  localparam logic [5:0] subAluLast = 6'd15;
  localparam logic [5:0] subShiftFirst = 6'd16;
  localparam logic [5:0] subShiftLast = 6'd19;
  localparam logic [5:0] subOddShiftFirst = 6'd20;
  localparam logic [5:0] subOddShiftLast = 6'd31;
  localparam logic [5:0] subJumpFirst = 6'd48;
  localparam logic [5:0] subJumpLast = 6'd51;

endpackage

//--- src/bundlePkg.sv
package bundlePkg;

  // fetch bundle layout
  localparam int parcelWidth = 16;
  localparam int parcelCount = 15;
  localparam int bundleWidth = 256;
  localparam int endBitBase = 240;
  localparam int wideBit = 255;

  // packed output geometry
  localparam int slotCount = 12;
  localparam int jumpSlotCount = 4;

  localparam int offWidth = 4;
  // inverted end bits of the parcel and the next three
  localparam int magicWidth = 4;

  typedef logic [offWidth-1:0] parcelIndex;

endpackage

//--- src/bundleCapture.sv
`timescale 1ns/1ps

module bundleCapture (
  input  logic clk,
  input  logic reset,
  input  logic bundleValid,
  input  logic [bundlePkg::bundleWidth-1:0] bundle,
  input  bundlePkg::parcelIndex startOff,
  output logic capValid,
  output logic capOffErr,
  output logic capWide,
  output logic [(bundlePkg::parcelCount+2)*bundlePkg::parcelWidth-1:0] capParcels,
  output logic [bundlePkg::parcelCount-1:0] capEnds,
  output logic [bundlePkg::parcelCount-1:0] capMask
);

  localparam int parcels = bundlePkg::parcelCount;
  localparam int payloadWidth = parcels * bundlePkg::parcelWidth;

  logic [payloadWidth-1:0] parcelReg;
  logic [parcels:0] maskNext;

  // thermometer from startOff upward, empty for offset 15
  assign maskNext = {(parcels+1){1'b1}} << startOff;

  always_ff @(posedge clk) begin
    if (reset) begin
      capValid <= 1'b0;
      capOffErr <= 1'b0;
    end else begin
      capValid <= bundleValid;
      capOffErr <= bundleValid && (startOff == bundlePkg::parcelIndex'(parcels));
    end
  end

  always_ff @(posedge clk) begin
    if (bundleValid) begin
      parcelReg <= bundle[payloadWidth-1:0];
      capEnds <= bundle[bundlePkg::endBitBase +: parcels];
      capWide <= bundle[bundlePkg::wideBit];
      capMask <= maskNext[parcels-1:0];
    end
  end

  // two spare parcels so the last window reads zeros
  assign capParcels = {{(2*bundlePkg::parcelWidth){1'b0}}, parcelReg};

  maskContiguous: assert property (@(posedge clk) disable iff (reset)
    bundleValid |=> ((capMask[parcels-2:0] & ~capMask[parcels-1:1]) == '0));

endmodule

//--- src/parcelClassifier.sv
`timescale 1ns/1ps

module parcelClassifier (
  input  isaPkg::instrWord word,
  input  logic [bundlePkg::magicWidth-1:0] magic,
  output isaPkg::instrClass cls
);

  logic isLong;
  logic [7:0] mainOp;
  logic [5:0] subOp;

  // end bit clear at this parcel means a multi-parcel long form
  assign isLong = magic[0];
  assign mainOp = word.longForm.mainOp;
  assign subOp = word.compactForm.subOp;

  always_comb begin
    cls = '0;
    if (isLong) begin
      if (mainOp <= isaPkg::aluMulLast) begin
        // bit 2 splits mul from plain ALU
        if (mainOp[2]) begin
          cls[isaPkg::clsMul] = 1'b1;
        end else begin
          cls[isaPkg::clsAlu] = 1'b1;
        end
      end
      if (mainOp >= isaPkg::shiftFirst && mainOp <= isaPkg::shiftLast) begin
        cls[isaPkg::clsShift] = 1'b1;
      end
      if (mainOp >= isaPkg::aluFirst && mainOp <= isaPkg::aluLast) begin
        cls[isaPkg::clsAlu] = 1'b1;
      end
      if (mainOp >= isaPkg::memFirst && mainOp <= isaPkg::memLast) begin
        // odd opcodes store
        if (mainOp[0]) begin
          cls[isaPkg::clsStore] = 1'b1;
        end else begin
          cls[isaPkg::clsLoad] = 1'b1;
        end
      end
      if (mainOp >= isaPkg::condJumpFirst && mainOp <= isaPkg::condJumpLast) begin
        cls[isaPkg::clsJump] = 1'b1;
        cls[isaPkg::clsAlu] = 1'b1;
      end
      if (mainOp >= isaPkg::longJumpFirst && mainOp <= isaPkg::longJumpLast) begin
        cls[isaPkg::clsJump] = 1'b1;
      end
      if (mainOp == isaPkg::sysOpcode) begin
        cls[isaPkg::clsSys] = 1'b1;
      end
    end else begin
      if (subOp <= isaPkg::subAluLast) begin
        cls[isaPkg::clsAlu] = 1'b1;
      end
      if (subOp >= isaPkg::subShiftFirst && subOp <= isaPkg::subShiftLast) begin
        cls[isaPkg::clsShift] = 1'b1;
      end
      if (subOp >= isaPkg::subOddShiftFirst && subOp <= isaPkg::subOddShiftLast && subOp[0]) begin
        cls[isaPkg::clsShift] = 1'b1;
      end
      if (subOp >= isaPkg::subJumpFirst && subOp <= isaPkg::subJumpLast) begin
        cls[isaPkg::clsJump] = 1'b1;
      end
    end
  end

endmodule

//--- src/classifyStage.sv
`timescale 1ns/1ps

module classifyStage (
  input  logic clk,
  input  logic reset,
  input  logic capValid,
  input  logic capOffErr,
  input  logic capWide,
  input  logic [(bundlePkg::parcelCount+2)*bundlePkg::parcelWidth-1:0] capParcels,
  input  logic [bundlePkg::parcelCount-1:0] capEnds,
  input  logic [bundlePkg::parcelCount-1:0] capMask,
  output logic clsValid,
  output logic clsOffErr,
  output logic clsWide,
  output isaPkg::instrWord [bundlePkg::parcelCount-1:0] clsWords,
  output logic [bundlePkg::parcelCount-1:0][bundlePkg::magicWidth-1:0] clsMagic,
  output isaPkg::instrClass [bundlePkg::parcelCount-1:0] clsClass,
  output logic [bundlePkg::parcelCount-1:0] clsStart
);

  localparam int parcels = bundlePkg::parcelCount;
  localparam int pw = bundlePkg::parcelWidth;
  localparam int mw = bundlePkg::magicWidth;

  logic [parcels+mw-2:0] endsExt;
  logic [parcels-1:0] prevEnd;
  isaPkg::instrWord [parcels-1:0] words;
  logic [parcels-1:0][mw-1:0] magic;
  isaPkg::instrClass [parcels-1:0] classes;
  logic [parcels-1:0] start;

  // end bits past the last parcel read as clear
  assign endsExt = {{(mw-1){1'b0}}, capEnds};
  assign prevEnd = {capEnds[parcels-2:0], 1'b1};

  for (genvar k = 0; k < parcels; k++) begin : gParcel
    assign words[k] = capParcels[k*pw +: 2*pw];
    assign magic[k] = ~endsExt[k +: mw];
    // needs a terminating end bit somewhere ahead
    assign start[k] = prevEnd[k] & capMask[k] & (|capEnds[parcels-1:k]);

    parcelClassifier classifier (
      .word(words[k]),
      .magic(magic[k]),
      .cls(classes[k])
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      clsValid <= 1'b0;
      clsOffErr <= 1'b0;
    end else begin
      clsValid <= capValid;
      clsOffErr <= capOffErr;
    end
  end

  always_ff @(posedge clk) begin
    clsWide <= capWide;
    clsWords <= words;
    clsMagic <= magic;
    clsClass <= classes;
    clsStart <= start;
  end

endmodule

//--- src/slotPacker.sv
`timescale 1ns/1ps

module slotPacker #(
  parameter int slotCount = bundlePkg::slotCount,
  parameter int jumpSlotCount = bundlePkg::jumpSlotCount
) (
  input  logic clk,
  input  logic reset,
  input  logic clsValid,
  input  logic clsOffErr,
  input  logic clsWide,
  input  isaPkg::instrWord [bundlePkg::parcelCount-1:0] clsWords,
  input  logic [bundlePkg::parcelCount-1:0][bundlePkg::magicWidth-1:0] clsMagic,
  input  isaPkg::instrClass [bundlePkg::parcelCount-1:0] clsClass,
  input  logic [bundlePkg::parcelCount-1:0] clsStart,
  output logic outValid,
  output logic isWide,
  output logic [slotCount-1:0] slotEn,
  output isaPkg::instrWord [slotCount-1:0] slotWord,
  output bundlePkg::parcelIndex [slotCount-1:0] slotOff,
  output logic [slotCount-1:0][bundlePkg::magicWidth-1:0] slotMagic,
  output isaPkg::instrClass [slotCount-1:0] slotClass,
  output logic [jumpSlotCount-1:0] jumpEn,
  output isaPkg::instrWord [jumpSlotCount-1:0] jumpWord,
  output bundlePkg::parcelIndex [jumpSlotCount-1:0] jumpOff,
  output isaPkg::instrClass [jumpSlotCount-1:0] jumpClass,
  output logic hasJumps,
  output logic countErr,
  output logic jumpErr
);

  localparam int parcels = bundlePkg::parcelCount;
  localparam int rankWidth = $clog2(parcels + 1);

  logic [parcels-1:0] jumpStart;
  logic [parcels:0][rankWidth-1:0] startRank;
  logic [parcels:0][rankWidth-1:0] jumpRank;
  logic [slotCount-1:0] slotEnNext;
  isaPkg::instrWord [slotCount-1:0] slotWordNext;
  bundlePkg::parcelIndex [slotCount-1:0] slotOffNext;
  logic [slotCount-1:0][bundlePkg::magicWidth-1:0] slotMagicNext;
  isaPkg::instrClass [slotCount-1:0] slotClassNext;
  logic [jumpSlotCount-1:0] jumpEnNext;
  isaPkg::instrWord [jumpSlotCount-1:0] jumpWordNext;
  bundlePkg::parcelIndex [jumpSlotCount-1:0] jumpOffNext;
  isaPkg::instrClass [jumpSlotCount-1:0] jumpClassNext;

  for (genvar k = 0; k < parcels; k++) begin : gJump
    assign jumpStart[k] = clsStart[k] & clsClass[k][isaPkg::clsJump];
  end

  // rank of parcel k is the count of starts below it
  always_comb begin
    startRank[0] = '0;
    jumpRank[0] = '0;
    for (int k = 0; k < parcels; k++) begin
      startRank[k+1] = startRank[k] + rankWidth'(clsStart[k]);
      jumpRank[k+1] = jumpRank[k] + rankWidth'(jumpStart[k]);
    end
  end

  always_comb begin
    slotEnNext = '0;
    slotWordNext = '0;
    slotOffNext = '0;
    slotMagicNext = '0;
    slotClassNext = '0;
    jumpEnNext = '0;
    jumpWordNext = '0;
    jumpOffNext = '0;
    jumpClassNext = '0;
    if (clsValid) begin
      for (int i = 0; i < slotCount; i++) begin
        for (int k = 0; k < parcels; k++) begin
          if (clsStart[k] && startRank[k] == rankWidth'(i)) begin
            slotEnNext[i] = 1'b1;
            slotWordNext[i] = clsWords[k];
            slotOffNext[i] = bundlePkg::parcelIndex'(k);
            slotMagicNext[i] = clsMagic[k];
            slotClassNext[i] = clsClass[k];
          end
        end
      end
      for (int j = 0; j < jumpSlotCount; j++) begin
        for (int k = 0; k < parcels; k++) begin
          if (jumpStart[k] && jumpRank[k] == rankWidth'(j)) begin
            jumpEnNext[j] = 1'b1;
            jumpWordNext[j] = clsWords[k];
            jumpOffNext[j] = bundlePkg::parcelIndex'(k);
            jumpClassNext[j] = clsClass[k];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      slotEn <= '0;
      jumpEn <= '0;
      hasJumps <= 1'b0;
      countErr <= 1'b0;
      jumpErr <= 1'b0;
    end else begin
      outValid <= clsValid;
      slotEn <= slotEnNext;
      jumpEn <= jumpEnNext;
      hasJumps <= clsValid && (jumpRank[parcels] != '0);
      countErr <= clsValid && (startRank[parcels] > slotCount || clsOffErr);
      jumpErr <= clsValid && (jumpRank[parcels] > jumpSlotCount);
    end
  end

  always_ff @(posedge clk) begin
    isWide <= clsWide;
    slotWord <= slotWordNext;
    slotOff <= slotOffNext;
    slotMagic <= slotMagicNext;
    slotClass <= slotClassNext;
    jumpWord <= jumpWordNext;
    jumpOff <= jumpOffNext;
    jumpClass <= jumpClassNext;
  end

  // all-ones prefix pattern
  slotEnPrefix: assert property (@(posedge clk) disable iff (reset)
    ((slotEn + 1'b1) & slotEn) == '0);

  jumpEnIdle: assert property (@(posedge clk) disable iff (reset)
    !outValid |-> jumpEn == '0);

endmodule

//--- src/predecoder.sv
`timescale 1ns/1ps

module predecoder #(
  parameter int slotCount = bundlePkg::slotCount,
  parameter int jumpSlotCount = bundlePkg::jumpSlotCount
) (
  input  logic clk,
  input  logic reset,
  input  logic bundleValid,
  input  logic [bundlePkg::bundleWidth-1:0] bundle,
  input  bundlePkg::parcelIndex startOff,
  output logic outValid,
  output logic [slotCount-1:0] slotEn,
  output isaPkg::instrWord [slotCount-1:0] slotWord,
  output bundlePkg::parcelIndex [slotCount-1:0] slotOff,
  output logic [slotCount-1:0][bundlePkg::magicWidth-1:0] slotMagic,
  output isaPkg::instrClass [slotCount-1:0] slotClass,
  output logic [jumpSlotCount-1:0] jumpEn,
  output isaPkg::instrWord [jumpSlotCount-1:0] jumpWord,
  output bundlePkg::parcelIndex [jumpSlotCount-1:0] jumpOff,
  output isaPkg::instrClass [jumpSlotCount-1:0] jumpClass,
  output logic hasJumps,
  output logic countErr,
  output logic jumpErr,
  output logic isWide
);

  localparam int parcels = bundlePkg::parcelCount;

  logic capValid;
  logic capOffErr;
  logic capWide;
  logic [(parcels+2)*bundlePkg::parcelWidth-1:0] capParcels;
  logic [parcels-1:0] capEnds;
  logic [parcels-1:0] capMask;

  logic clsValid;
  logic clsOffErr;
  logic clsWide;
  isaPkg::instrWord [parcels-1:0] clsWords;
  logic [parcels-1:0][bundlePkg::magicWidth-1:0] clsMagic;
  isaPkg::instrClass [parcels-1:0] clsClass;
  logic [parcels-1:0] clsStart;

  bundleCapture capture (
    .clk, .reset, .bundleValid, .bundle, .startOff,
    .capValid, .capOffErr, .capWide, .capParcels, .capEnds, .capMask
  );

  classifyStage classify (
    .clk, .reset, .capValid, .capOffErr, .capWide, .capParcels, .capEnds, .capMask,
    .clsValid, .clsOffErr, .clsWide, .clsWords, .clsMagic, .clsClass, .clsStart
  );

  slotPacker #(
    .slotCount(slotCount),
    .jumpSlotCount(jumpSlotCount)
  ) packer (
    .clk, .reset, .clsValid, .clsOffErr, .clsWide,
    .clsWords, .clsMagic, .clsClass, .clsStart,
    .outValid, .isWide,
    .slotEn, .slotWord, .slotOff, .slotMagic, .slotClass,
    .jumpEn, .jumpWord, .jumpOff, .jumpClass,
    .hasJumps, .countErr, .jumpErr
  );

endmodule

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- bench/predecoderChecker.sv
`timescale 1ns/1ps

module predecoderChecker #(
  parameter int slotCount = bundlePkg::slotCount,
  parameter int jumpSlotCount = bundlePkg::jumpSlotCount
) (
  input  logic clk,
  input  logic reset,
  input  logic bundleValid,
  input  logic [bundlePkg::bundleWidth-1:0] bundle,
  input  bundlePkg::parcelIndex startOff,
  input  logic outValid,
  input  logic [slotCount-1:0] slotEn,
  input  logic [slotCount-1:0][31:0] slotWord,
  input  logic [slotCount-1:0][bundlePkg::offWidth-1:0] slotOff,
  input  logic [slotCount-1:0][bundlePkg::magicWidth-1:0] slotMagic,
  input  logic [slotCount-1:0][isaPkg::classWidth-1:0] slotClass,
  input  logic [jumpSlotCount-1:0] jumpEn,
  input  logic [jumpSlotCount-1:0][31:0] jumpWord,
  input  logic [jumpSlotCount-1:0][bundlePkg::offWidth-1:0] jumpOff,
  input  logic [jumpSlotCount-1:0][isaPkg::classWidth-1:0] jumpClass,
  input  logic hasJumps,
  input  logic countErr,
  input  logic jumpErr,
  input  logic isWide,
  output int mismatches,
  output int checkedBundles,
  output int countErrSeen,
  output int jumpErrSeen,
  output logic [isaPkg::classWidth-1:0] classesSeen
);

  localparam int parcels = bundlePkg::parcelCount;

  // inputs as the DUT saw them, index 2 is three edges old
  logic histValid [3];
  logic [bundlePkg::bundleWidth-1:0] histBundle [3];
  bundlePkg::parcelIndex histOff [3];
  logic armed = 1'b0;

  logic [slotCount-1:0] expSlotEn;
  logic [slotCount-1:0][31:0] expSlotWord;
  logic [slotCount-1:0][bundlePkg::offWidth-1:0] expSlotOff;
  logic [slotCount-1:0][bundlePkg::magicWidth-1:0] expSlotMagic;
  logic [slotCount-1:0][isaPkg::classWidth-1:0] expSlotClass;
  logic [jumpSlotCount-1:0] expJumpEn;
  logic [jumpSlotCount-1:0][31:0] expJumpWord;
  logic [jumpSlotCount-1:0][bundlePkg::offWidth-1:0] expJumpOff;
  logic [jumpSlotCount-1:0][isaPkg::classWidth-1:0] expJumpClass;
  logic expHasJumps;
  logic expCountErr;
  logic expJumpErr;

  initial begin
    mismatches = 0;
    checkedBundles = 0;
    countErrSeen = 0;
    jumpErrSeen = 0;
    classesSeen = '0;
  end

  function automatic logic [isaPkg::classWidth-1:0] classOf(input logic [31:0] word,
                                                           input logic longForm);
    logic [7:0] op;
    logic [5:0] sub;
    logic [isaPkg::classWidth-1:0] c;
    op = word[7:0];
    sub = word[5:0];
    c = '0;
    if (longForm) begin
      if (op <= isaPkg::aluMulLast) begin
        c[op[2] ? isaPkg::clsMul : isaPkg::clsAlu] = 1'b1;
      end else if (op >= isaPkg::shiftFirst && op <= isaPkg::shiftLast) begin
        c[isaPkg::clsShift] = 1'b1;
      end else if (op >= isaPkg::aluFirst && op <= isaPkg::aluLast) begin
        c[isaPkg::clsAlu] = 1'b1;
      end else if (op >= isaPkg::memFirst && op <= isaPkg::memLast) begin
        c[op[0] ? isaPkg::clsStore : isaPkg::clsLoad] = 1'b1;
      end else if (op >= isaPkg::condJumpFirst && op <= isaPkg::condJumpLast) begin
        c[isaPkg::clsJump] = 1'b1;
        c[isaPkg::clsAlu] = 1'b1;
      end else if (op == isaPkg::longJumpFirst || op == isaPkg::longJumpLast) begin
        c[isaPkg::clsJump] = 1'b1;
      end else if (op == isaPkg::sysOpcode) begin
        c[isaPkg::clsSys] = 1'b1;
      end
    end else begin
      if (sub <= isaPkg::subAluLast) begin
        c[isaPkg::clsAlu] = 1'b1;
      end else if (sub <= isaPkg::subShiftLast) begin
        c[isaPkg::clsShift] = 1'b1;
      end else if (sub <= isaPkg::subOddShiftLast) begin
        c[isaPkg::clsShift] = sub[0];
      end else if (sub >= isaPkg::subJumpFirst && sub <= isaPkg::subJumpLast) begin
        c[isaPkg::clsJump] = 1'b1;
      end
    end
    return c;
  endfunction

  // expected outputs for one bundle, straight from the start and packing rules
  function automatic void predict(input logic valid, input logic [255:0] b,
                                  input bundlePkg::parcelIndex off);
    logic [parcels-1:0] ends;
    logic [parcels*16+31:0] payload;
    logic [31:0] word;
    logic [3:0] magic;
    logic [isaPkg::classWidth-1:0] cls;
    logic begins;
    int starts;
    int jumps;
    ends = b[bundlePkg::endBitBase +: parcels];
    payload = {32'b0, b[parcels*16-1:0]};
    starts = 0;
    jumps = 0;
    expSlotEn = '0;
    expSlotWord = '0;
    expSlotOff = '0;
    expSlotMagic = '0;
    expSlotClass = '0;
    expJumpEn = '0;
    expJumpWord = '0;
    expJumpOff = '0;
    expJumpClass = '0;
    for (int k = 0; k < parcels; k++) begin
      word = payload[k*16 +: 32];
      for (int m = 0; m < 4; m++) begin
        magic[m] = (k + m < parcels) ? ~ends[k+m] : 1'b1;
      end
      begins = valid && (k >= int'(off)) && ((k == 0) ? 1'b1 : ends[k-1]) &&
               ((ends >> k) != '0);
      cls = classOf(word, magic[0]);
      if (begins) begin
        if (starts < slotCount) begin
          expSlotEn[starts] = 1'b1;
          expSlotWord[starts] = word;
          expSlotOff[starts] = 4'(k);
          expSlotMagic[starts] = magic;
          expSlotClass[starts] = cls;
        end
        if (cls[isaPkg::clsJump]) begin
          if (jumps < jumpSlotCount) begin
            expJumpEn[jumps] = 1'b1;
            expJumpWord[jumps] = word;
            expJumpOff[jumps] = 4'(k);
            expJumpClass[jumps] = cls;
          end
          jumps++;
        end
        starts++;
      end
    end
    expHasJumps = jumps > 0;
    expCountErr = valid && (starts > slotCount || off == 4'd15);
    expJumpErr = jumps > jumpSlotCount;
  endfunction

  task automatic compare(input string name, input logic [383:0] expected,
                         input logic [383:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %0h actual %0h at %0t", name, expected, actual, $time);
      mismatches++;
    end
  endtask

  always @(posedge clk) begin
    armed = !reset;
    for (int i = 2; i > 0; i--) begin
      histValid[i] = histValid[i-1];
      histBundle[i] = histBundle[i-1];
      histOff[i] = histOff[i-1];
    end
    histValid[0] = bundleValid && !reset;
    histBundle[0] = bundle;
    histOff[0] = startOff;
  end

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (armed) begin
      predict(histValid[2], histBundle[2], histOff[2]);
      compare("outValid", histValid[2], outValid);
      compare("slotEn", expSlotEn, slotEn);
      compare("slotWord", expSlotWord, slotWord);
      compare("slotOff", expSlotOff, slotOff);
      compare("slotMagic", expSlotMagic, slotMagic);
      compare("slotClass", expSlotClass, slotClass);
      compare("jumpEn", expJumpEn, jumpEn);
      compare("jumpWord", expJumpWord, jumpWord);
      compare("jumpOff", expJumpOff, jumpOff);
      compare("jumpClass", expJumpClass, jumpClass);
      compare("hasJumps", expHasJumps, hasJumps);
      compare("countErr", expCountErr, countErr);
      compare("jumpErr", expJumpErr, jumpErr);
      if (histValid[2]) begin
        compare("isWide", histBundle[2][bundlePkg::wideBit], isWide);
        checkedBundles++;
        if (expCountErr) countErrSeen++;
        if (expJumpErr) jumpErrSeen++;
        for (int i = 0; i < slotCount; i++) begin
          classesSeen |= expSlotClass[i];
        end
      end
    end
  end

endmodule

//--- bench/predecoderTb.sv
`timescale 1ns/1ps

module predecoderTb;

  localparam int stimCycles = 2000;
  localparam int resetCycles = 16;
  localparam int latency = 3;
  localparam int timeoutCycles = resetCycles + stimCycles + latency + 81;
  localparam int slots = bundlePkg::slotCount;
  localparam int jumpSlots = bundlePkg::jumpSlotCount;

  logic clk;
  logic reset;
  logic bundleValid;
  logic [bundlePkg::bundleWidth-1:0] bundle;
  bundlePkg::parcelIndex startOff;

  logic outValid;
  logic [slots-1:0] slotEn;
  isaPkg::instrWord [slots-1:0] slotWord;
  bundlePkg::parcelIndex [slots-1:0] slotOff;
  logic [slots-1:0][bundlePkg::magicWidth-1:0] slotMagic;
  isaPkg::instrClass [slots-1:0] slotClass;
  logic [jumpSlots-1:0] jumpEn;
  isaPkg::instrWord [jumpSlots-1:0] jumpWord;
  bundlePkg::parcelIndex [jumpSlots-1:0] jumpOff;
  isaPkg::instrClass [jumpSlots-1:0] jumpClass;
  logic hasJumps;
  logic countErr;
  logic jumpErr;
  logic isWide;

  int mismatches;
  int checkedBundles;
  int countErrSeen;
  int jumpErrSeen;
  logic [isaPkg::classWidth-1:0] classesSeen;
  int failures = 0;
  int cycles = 0;
  logic [31:0] lfsr = 32'd77;

  clockGen clocks (.clk, .reset);

  predecoder DUT (.*);

  predecoderChecker monitor (.*);

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // one lfsr step per bit, lsb first
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
    return r;
  endfunction

  // low byte aimed at the class ranges
  function automatic logic [7:0] pickOpcode(input logic jumpHeavy);
    logic [2:0] group;
    logic [3:0] lo;
    group = 3'(takeBits(3));
    if (jumpHeavy && takeBits(1) != 0) group = 3'd5;
    lo = 4'(takeBits(4));
    case (group)
      3'd0: return 8'(takeBits(6));
      3'd1: return 8'd64 + 8'(takeBits(6));
      3'd2: return 8'd160 + 8'(lo);
      3'd3: return 8'd180 + 8'(lo[0]);
      3'd4: return 8'd255;
      // compact sub-opcodes 48 to 51
      3'd5: return {lo[3:2], 4'b1100, lo[1:0]};
      3'd6: return 8'd40 + 8'(lo[2:0]);
      default: return 8'(takeBits(8));
    endcase
  endfunction

  task automatic makeBundle();
    logic [1:0] mode;
    logic [bundlePkg::parcelCount-1:0] ends;
    mode = 2'(takeBits(2));
    for (int k = 0; k < bundlePkg::parcelCount; k++) begin
      bundle[k*16 +: 16] = 16'(takeBits(16));
      if (takeBits(2) != 0) bundle[k*16 +: 8] = pickOpcode(mode == 2'd0);
      // dense ends for count overflow, sparse ends for long forms
      case (mode)
        2'd0, 2'd1: ends[k] = takeBits(3) != 0;
        2'd2: ends[k] = 1'(takeBits(1));
        default: ends[k] = takeBits(2) == 0;
      endcase
    end
    bundle[bundlePkg::endBitBase +: bundlePkg::parcelCount] = ends;
    bundle[bundlePkg::wideBit] = 1'(takeBits(1));
    startOff = (takeBits(4) == 32'hf) ? 4'd15 : 4'(takeBits(2));
  endtask

  initial begin
    bundleValid = 1'b0;
    bundle = '0;
    startOff = '0;
    @(negedge reset);
    for (int c = 0; c < stimCycles; c++) begin
      @(negedge clk);
      bundleValid = takeBits(2) != 0;
      if (bundleValid) makeBundle();
    end
    @(negedge clk);
    bundleValid = 1'b0;
    repeat (latency + 1) @(negedge clk);
    @(posedge clk);
    if (checkedBundles == 0) begin
      $display("no bundle reached the outputs");
      failures++;
    end
    if (countErrSeen == 0) begin
      $display("no bundle raised the instruction-count error");
      failures++;
    end
    if (jumpErrSeen == 0) begin
      $display("no bundle raised the too-many-jumps error");
      failures++;
    end
    if (classesSeen != '1) begin
      $display("not every instruction class was exercised, seen %h", classesSeen);
      failures++;
    end
    $display("bundles checked %0d, mismatches %0d, other errors %0d",
             checkedBundles, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) begin
      $display("timeout after %0d cycles, the run did not finish", timeoutCycles);
      $display("Something failed");
      $finish;
    end
  end

endmodule

//--- all.f
src/isaPkg.sv
src/bundlePkg.sv
src/bundleCapture.sv
src/parcelClassifier.sv
src/classifyStage.sv
src/slotPacker.sv
src/predecoder.sv
bench/clockGen.sv
bench/predecoderChecker.sv
bench/predecoderTb.sv

//--- Bender.yml
package:
  name: predecoder

sources:
  - src/isaPkg.sv
  - src/bundlePkg.sv
  - src/bundleCapture.sv
  - src/parcelClassifier.sv
  - src/classifyStage.sv
  - src/slotPacker.sv
  - src/predecoder.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/predecoderChecker.sv
      - bench/predecoderTb.sv
